// File: src/bus_pkg.sv
package bus_pkg;

    // axi side of the peripheral
    localparam int unsigned AxiAddrWidth = 32;
    localparam int unsigned AxiDataWidth = 64;
    // one strobe bit per data byte
    localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;

    // register width, also the apb data width
    localparam int unsigned ApbDataWidth = 32;

    // apb signals from the outside master
    // paddr shares the axi address space width
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [AxiAddrWidth-1:0] paddr;
        logic [ApbDataWidth-1:0] pwdata;
    } apb_req_t;

    // apb response, no wait states so no pready
    typedef struct packed {
        logic [ApbDataWidth-1:0] prdata;
        logic                    pslverr;
    } apb_rsp_t;

    // master-driven axi signals, single beat only
    typedef struct packed {
        logic                    aw_valid;
        logic [AxiAddrWidth-1:0] aw_addr;
        logic                    w_valid;
        logic [AxiDataWidth-1:0] w_data;
        logic [AxiStrbWidth-1:0] w_strb;
        logic                    b_ready;
        logic                    ar_valid;
        logic [AxiAddrWidth-1:0] ar_addr;
        logic                    r_ready;
    } axi_req_t;

    // slave-driven axi signals
    typedef struct packed {
        logic                    aw_ready;
        logic                    w_ready;
        logic                    b_valid;
        logic [1:0]              b_resp;
        logic                    ar_ready;
        logic                    r_valid;
        logic [AxiDataWidth-1:0] r_data;
        logic [1:0]              r_resp;
    } axi_rsp_t;

endpackage

// File: src/regmap_pkg.sv
package regmap_pkg;

    // register offsets within the apb window
    typedef enum logic [7:0] {
        OFF_OP_A   = 8'h00,
        OFF_OP_B   = 8'h04,
        OFF_SUM    = 8'h08,
        OFF_ADDR   = 8'h10,
        OFF_RDATA  = 8'h18,
        OFF_WDATA  = 8'h20,
        OFF_CMD    = 8'h28,
        OFF_STATUS = 8'h2C
    } reg_offset_e;

    // bit positions, same in the command and the status word
    localparam int unsigned CmdWriteBit = 0;
    localparam int unsigned CmdReadBit  = 1;

    // register block to axi master
    // start bits are one-cycle pulses
    typedef struct packed {
        logic                             start_write;
        logic                             start_read;
        logic [bus_pkg::AxiAddrWidth-1:0] addr;
        logic [bus_pkg::ApbDataWidth-1:0] wdata;
    } master_cmd_t;

    // axi master back to register block
    typedef struct packed {
        logic [bus_pkg::ApbDataWidth-1:0] rdata;
        logic                             wr_busy;
        logic                             rd_busy;
    } master_stat_t;

endpackage

// File: src/test_reg_block.sv
`timescale 1ns/1ns

module test_reg_block #(
    parameter int unsigned RegAddrBits = 8
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  bus_pkg::apb_req_t        apb_req_i,
    output bus_pkg::apb_rsp_t        apb_rsp_o,
    output regmap_pkg::master_cmd_t  cmd_o,
    input  regmap_pkg::master_stat_t stat_i
);

    // decoded low part of paddr
    logic [RegAddrBits-1:0] reg_addr;
    // access phase of an apb transfer
    logic access;
    logic wr_en;
    logic cmd_wr;

    // software-visible registers
    logic [bus_pkg::ApbDataWidth-1:0] op_a_q;
    logic [bus_pkg::ApbDataWidth-1:0] op_b_q;
    logic [bus_pkg::AxiAddrWidth-1:0] addr_q;
    logic [bus_pkg::ApbDataWidth-1:0] wdata_q;
    logic start_wr_q;
    logic start_rd_q;

    logic [bus_pkg::ApbDataWidth-1:0] sum;
    logic [bus_pkg::ApbDataWidth-1:0] status_word;
    logic [bus_pkg::ApbDataWidth-1:0] rdata;
    logic err;

    assign reg_addr = apb_req_i.paddr[RegAddrBits-1:0];
    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign wr_en    = access & apb_req_i.pwrite;
    assign cmd_wr   = wr_en && (reg_addr == RegAddrBits'(regmap_pkg::OFF_CMD));

    // wraps mod 2^32 by width
    assign sum = op_a_q + op_b_q;

    // busy flags at the command bit positions
    always_comb begin
        status_word = '0;
        status_word[regmap_pkg::CmdWriteBit] = stat_i.wr_busy;
        status_word[regmap_pkg::CmdReadBit]  = stat_i.rd_busy;
    end

    // read mux and error decode
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (reg_addr)
            RegAddrBits'(regmap_pkg::OFF_OP_A):   rdata = op_a_q;
            RegAddrBits'(regmap_pkg::OFF_OP_B):   rdata = op_b_q;
            RegAddrBits'(regmap_pkg::OFF_ADDR):   rdata = addr_q;
            RegAddrBits'(regmap_pkg::OFF_WDATA):  rdata = wdata_q;
            // write-only, reads back zero
            RegAddrBits'(regmap_pkg::OFF_CMD):    rdata = '0;
            // read-only registers, writing them is an error
            RegAddrBits'(regmap_pkg::OFF_SUM): begin
                rdata = sum;
                err   = apb_req_i.pwrite;
            end
            RegAddrBits'(regmap_pkg::OFF_RDATA): begin
                rdata = stat_i.rdata;
                err   = apb_req_i.pwrite;
            end
            RegAddrBits'(regmap_pkg::OFF_STATUS): begin
                rdata = status_word;
                err   = apb_req_i.pwrite;
            end
            // unmapped offset
            default: err = 1'b1;
        endcase
    end

    // errored accesses return zero
    assign apb_rsp_o.prdata  = err ? '0 : rdata;
    assign apb_rsp_o.pslverr = access & err;

    // register writes at the end of the access cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_a_q  <= '0;
            op_b_q  <= '0;
            addr_q  <= '0;
            wdata_q <= '0;
        end else if (wr_en) begin
            case (reg_addr)
                RegAddrBits'(regmap_pkg::OFF_OP_A):  op_a_q  <= apb_req_i.pwdata;
                RegAddrBits'(regmap_pkg::OFF_OP_B):  op_b_q  <= apb_req_i.pwdata;
                RegAddrBits'(regmap_pkg::OFF_ADDR):  addr_q  <= apb_req_i.pwdata;
                RegAddrBits'(regmap_pkg::OFF_WDATA): wdata_q <= apb_req_i.pwdata;
                // read-only and unmapped offsets keep their value
                default: ;
            endcase
        end
    end

    // start pulses, one cycle after the cmd write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_wr_q <= 1'b0;
            start_rd_q <= 1'b0;
        end else begin
            start_wr_q <= cmd_wr & apb_req_i.pwdata[regmap_pkg::CmdWriteBit];
            start_rd_q <= cmd_wr & apb_req_i.pwdata[regmap_pkg::CmdReadBit];
        end
    end

    assign cmd_o.start_write = start_wr_q;
    assign cmd_o.start_read  = start_rd_q;
    assign cmd_o.addr        = addr_q;
    assign cmd_o.wdata       = wdata_q;

endmodule

// File: src/axi_single_master.sv
`timescale 1ns/1ns

module axi_single_master (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  regmap_pkg::master_cmd_t  cmd_i,
    output regmap_pkg::master_stat_t stat_o,
    output bus_pkg::axi_req_t        axi_req_o,
    input  bus_pkg::axi_rsp_t        axi_rsp_i
);

    // one pending flag per channel
    logic aw_pend_q;
    logic w_pend_q;
    logic ar_pend_q;
    logic r_pend_q;

    // payload held for the whole transfer
    logic [bus_pkg::AxiAddrWidth-1:0] wr_addr_q;
    logic [bus_pkg::ApbDataWidth-1:0] wr_data_q;
    logic [bus_pkg::AxiAddrWidth-1:0] rd_addr_q;
    logic [bus_pkg::ApbDataWidth-1:0] rdata_q;

    logic wr_busy;
    logic rd_busy;
    logic wr_start;
    logic rd_start;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic r_hs;

    assign wr_busy = aw_pend_q | w_pend_q;
    assign rd_busy = ar_pend_q | r_pend_q;

    // starts for a busy direction are dropped
    assign wr_start = cmd_i.start_write & ~wr_busy;
    assign rd_start = cmd_i.start_read & ~rd_busy;

    assign aw_hs = aw_pend_q & axi_rsp_i.aw_ready;
    assign w_hs  = w_pend_q & axi_rsp_i.w_ready;
    assign ar_hs = ar_pend_q & axi_rsp_i.ar_ready;
    assign r_hs  = r_pend_q & axi_rsp_i.r_valid;

    // channel tracking, each flag cleared by its own handshake
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            ar_pend_q <= 1'b0;
            r_pend_q  <= 1'b0;
            rdata_q   <= '0;
        end else begin
            if (wr_start) begin
                aw_pend_q <= 1'b1;
                w_pend_q  <= 1'b1;
            end else begin
                if (aw_hs) aw_pend_q <= 1'b0;
                if (w_hs) w_pend_q <= 1'b0;
            end
            if (rd_start) begin
                ar_pend_q <= 1'b1;
                r_pend_q  <= 1'b1;
            end else begin
                if (ar_hs) ar_pend_q <= 1'b0;
                if (r_hs) r_pend_q <= 1'b0;
            end
            // pick the 32-bit lane by address bit 2
            if (r_hs) begin
                rdata_q <= rd_addr_q[2] ? axi_rsp_i.r_data[63:32] : axi_rsp_i.r_data[31:0];
            end
        end
    end

    // latch address and data when a transfer is accepted
    always_ff @(posedge clk_i) begin
        if (wr_start) begin
            wr_addr_q <= cmd_i.addr;
            wr_data_q <= cmd_i.wdata;
        end
        if (rd_start) begin
            rd_addr_q <= cmd_i.addr;
        end
    end

    always_comb begin
        axi_req_o.aw_valid = aw_pend_q;
        // 8-byte aligned, lane picked by strobe
        axi_req_o.aw_addr  = {wr_addr_q[bus_pkg::AxiAddrWidth-1:3], 3'b000};
        axi_req_o.w_valid  = w_pend_q;
        // same word in both lanes
        axi_req_o.w_data   = {2{wr_data_q}};
        axi_req_o.w_strb   = wr_addr_q[2] ? 8'hF0 : 8'h0F;
        // write response not checked
        axi_req_o.b_ready  = 1'b1;
        axi_req_o.ar_valid = ar_pend_q;
        axi_req_o.ar_addr  = {rd_addr_q[bus_pkg::AxiAddrWidth-1:3], 3'b000};
        axi_req_o.r_ready  = r_pend_q;
    end

    assign stat_o.rdata   = rdata_q;
    assign stat_o.wr_busy = wr_busy;
    assign stat_o.rd_busy = rd_busy;

endmodule

// File: src/axi_test_periph.sv
`timescale 1ns/1ns

module axi_test_periph #(
    parameter int unsigned RegAddrBits = 8
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  bus_pkg::apb_req_t apb_req_i,
    output bus_pkg::apb_rsp_t apb_rsp_o,
    output bus_pkg::axi_req_t axi_req_o,
    input  bus_pkg::axi_rsp_t axi_rsp_i
);

    // start pulses, target address and write data
    regmap_pkg::master_cmd_t  master_cmd;
    // read data and busy flags
    regmap_pkg::master_stat_t master_stat;

    // apb side
    test_reg_block #(
        .RegAddrBits ( RegAddrBits )
    ) i_test_reg_block (
        .clk_i     ( clk_i       ),
        .rst_ni    ( rst_ni      ),
        .apb_req_i ( apb_req_i   ),
        .apb_rsp_o ( apb_rsp_o   ),
        .cmd_o     ( master_cmd  ),
        .stat_i    ( master_stat )
    );

    // axi side
    axi_single_master i_axi_single_master (
        .clk_i     ( clk_i       ),
        .rst_ni    ( rst_ni      ),
        .cmd_i     ( master_cmd  ),
        .stat_o    ( master_stat ),
        .axi_req_o ( axi_req_o   ),
        .axi_rsp_i ( axi_rsp_i   )
    );

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        // reset held over three rising edges
        repeat (3) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

    // 10 ns period
    always #5 clk_o = ~clk_o;

endmodule

// File: sim/tb_axi_mem.sv
`timescale 1ns/1ns

module tb_axi_mem (
    input  logic              clk_i,
    input  bus_pkg::axi_req_t req_i,
    output bus_pkg::axi_rsp_t rsp_o
);

    // 256 words, word index is addr[10:3]
    logic [63:0] mem [256];
    logic [31:0] seed;
    // request as seen in the middle of the cycle
    bus_pkg::axi_req_t req_s;
    logic [2:0] aw_cnt, w_cnt, ar_cnt, r_cnt;
    logic aw_held, w_held, rd_pend, hs;
    logic [31:0] wr_addr, rd_addr;
    logic [63:0] wr_data;
    logic [7:0] wr_strb;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // 0 to 7 cycles
    function automatic logic [2:0] next_delay();
        seed = xorshift(seed);
        return seed[2:0];
    endfunction

    // hold ready low for a random count while valid waits
    task automatic pace(input logic valid, inout logic rdy, inout logic [2:0] cnt,
                        output logic done);
        done = valid & rdy;
        if (done) begin
            rdy = 1'b0;
            cnt = next_delay();
        end else if (valid) begin
            if (cnt == 3'd0) rdy = 1'b1;
            else cnt = cnt - 3'd1;
        end
    endtask

    initial begin
        seed    = 32'h4063;
        rsp_o   = '0;
        aw_held = 1'b0;
        w_held  = 1'b0;
        rd_pend = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {32'hC0DE_0000 + i, 32'h0BAD_0000 ^ i};
        end
        aw_cnt = next_delay();
        w_cnt  = next_delay();
        ar_cnt = next_delay();
        r_cnt  = next_delay();
        forever begin
            @(negedge clk_i);
            req_s = req_i;
            @(posedge clk_i);
            #1;
            rsp_o.b_valid = 1'b0;
            pace(req_s.aw_valid, rsp_o.aw_ready, aw_cnt, hs);
            if (hs) begin
                aw_held = 1'b1;
                wr_addr = req_s.aw_addr;
            end
            pace(req_s.w_valid, rsp_o.w_ready, w_cnt, hs);
            if (hs) begin
                w_held  = 1'b1;
                wr_data = req_s.w_data;
                wr_strb = req_s.w_strb;
            end
            // both halves in, commit the bytes under the strobe
            if (aw_held && w_held) begin
                for (int b = 0; b < 8; b++) begin
                    if (wr_strb[b]) mem[wr_addr[10:3]][8*b +: 8] = wr_data[8*b +: 8];
                end
                $display("%0t mem write beat addr %h data %h strb %h",
                         $time, wr_addr, wr_data, wr_strb);
                aw_held       = 1'b0;
                w_held        = 1'b0;
                rsp_o.b_valid = 1'b1;
            end
            pace(req_s.ar_valid, rsp_o.ar_ready, ar_cnt, hs);
            if (hs) begin
                rd_addr = req_s.ar_addr;
                rd_pend = 1'b1;
            end
            // r valid is paced here, ready comes from the master
            if (rsp_o.r_valid && req_s.r_ready) begin
                rsp_o.r_valid = 1'b0;
                r_cnt         = next_delay();
            end else if (rd_pend) begin
                if (r_cnt == 3'd0) begin
                    rsp_o.r_valid = 1'b1;
                    rsp_o.r_data  = mem[rd_addr[10:3]];
                    rd_pend       = 1'b0;
                end else begin
                    r_cnt = r_cnt - 3'd1;
                end
            end
        end
    end

endmodule

// File: sim/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  bus_pkg::apb_req_t apb_req_i,
    input  bus_pkg::apb_rsp_t apb_rsp_i,
    input  bus_pkg::axi_req_t axi_req_i,
    input  bus_pkg::axi_rsp_t axi_rsp_i,
    // expectation for the current apb access
    input  logic              chk_en_i,
    input  logic              chk_data_i,
    input  logic [31:0]       exp_prdata_i,
    input  logic              exp_pslverr_i,
    output int                apb_errs_o,
    output int                axi_errs_o,
    output int                beats_o
);

    int apb_errs = 0;
    int axi_errs = 0;
    int beats = 0;
    // last address and data software wrote
    logic [31:0] sw_addr = '0;
    logic [31:0] sw_wdata = '0;
    // pair latched by the last write command
    logic [31:0] exp_addr = '0;
    logic [31:0] exp_wdata = '0;
    // address latched by the last read command
    logic [31:0] exp_rd_addr = '0;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want,
                           inout int errs);
        if (got !== want) begin
            errs++;
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, want, got);
        end
    endtask

    // sampled mid-cycle once inputs have settled
    always @(negedge clk_i) begin
        if (rst_ni && apb_req_i.psel && apb_req_i.penable) begin
            if (chk_en_i) begin
                compare("pslverr", {63'h0, apb_rsp_i.pslverr}, {63'h0, exp_pslverr_i}, apb_errs);
                if (chk_data_i) begin
                    compare("prdata", {32'h0, apb_rsp_i.prdata}, {32'h0, exp_prdata_i}, apb_errs);
                end
            end
            if (apb_req_i.pwrite) begin
                case (apb_req_i.paddr[7:0])
                    regmap_pkg::OFF_ADDR:  sw_addr = apb_req_i.pwdata;
                    regmap_pkg::OFF_WDATA: sw_wdata = apb_req_i.pwdata;
                    regmap_pkg::OFF_CMD: begin
                        if (apb_req_i.pwdata[regmap_pkg::CmdWriteBit]) begin
                            exp_addr  = sw_addr;
                            exp_wdata = sw_wdata;
                        end
                        if (apb_req_i.pwdata[regmap_pkg::CmdReadBit]) begin
                            exp_rd_addr = sw_addr;
                        end
                    end
                    default: ;
                endcase
            end
        end
        // write beat carries the aligned address and the word in both lanes
        if (rst_ni && axi_req_i.aw_valid && axi_rsp_i.aw_ready) begin
            compare("aw_addr", {32'h0, axi_req_i.aw_addr}, {32'h0, exp_addr[31:3], 3'b000},
                    axi_errs);
        end
        // strobe picked by address bit 2
        if (rst_ni && axi_req_i.w_valid && axi_rsp_i.w_ready) begin
            compare("w_data", axi_req_i.w_data, {2{exp_wdata}}, axi_errs);
            compare("w_strb", {56'h0, axi_req_i.w_strb}, exp_addr[2] ? 64'hF0 : 64'h0F,
                    axi_errs);
            beats++;
        end
        // read address aligned to the 64-bit word
        if (rst_ni && axi_req_i.ar_valid && axi_rsp_i.ar_ready) begin
            compare("ar_addr", {32'h0, axi_req_i.ar_addr},
                    {32'h0, exp_rd_addr[31:3], 3'b000}, axi_errs);
        end
        // write responses always accepted
        if (rst_ni && axi_rsp_i.b_valid) begin
            compare("b_ready", {63'h0, axi_req_i.b_ready}, 64'h1, axi_errs);
        end
    end

    assign apb_errs_o = apb_errs;
    assign axi_errs_o = axi_errs;
    assign beats_o    = beats;

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    localparam logic [1:0] KindWr   = 2'd0;
    localparam logic [1:0] KindRd   = 2'd1;
    localparam logic [1:0] KindIdle = 2'd2;

    // one table row, err is the expected pslverr
    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  off;
        logic [31:0] data;
        logic        err;
    } entry_t;

    logic clk, rst_n;
    bus_pkg::apb_req_t apb_req;
    bus_pkg::apb_rsp_t apb_rsp;
    bus_pkg::axi_req_t axi_req;
    bus_pkg::axi_rsp_t axi_rsp;
    logic chk_en, chk_data, exp_pslverr;
    logic [31:0] exp_prdata, rdata;
    int apb_errs, axi_errs, beats;
    entry_t stim_q[$];
    int exp_beats = 0;
    int cycle_cnt = 0;
    int timeout_cycles;

    tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

    axi_test_periph #(
        .RegAddrBits ( 8 )
    ) dut0 (
        .clk_i     ( clk     ),
        .rst_ni    ( rst_n   ),
        .apb_req_i ( apb_req ),
        .apb_rsp_o ( apb_rsp ),
        .axi_req_o ( axi_req ),
        .axi_rsp_i ( axi_rsp )
    );

    tb_axi_mem i_axi_mem (.clk_i(clk), .req_i(axi_req), .rsp_o(axi_rsp));

    tb_checker i_checker (
        .clk_i         ( clk         ),
        .rst_ni        ( rst_n       ),
        .apb_req_i     ( apb_req     ),
        .apb_rsp_i     ( apb_rsp     ),
        .axi_req_i     ( axi_req     ),
        .axi_rsp_i     ( axi_rsp     ),
        .chk_en_i      ( chk_en      ),
        .chk_data_i    ( chk_data    ),
        .exp_prdata_i  ( exp_prdata  ),
        .exp_pslverr_i ( exp_pslverr ),
        .apb_errs_o    ( apb_errs    ),
        .axi_errs_o    ( axi_errs    ),
        .beats_o       ( beats       )
    );

    task automatic add(input logic [1:0] kind, input logic [7:0] off, input logic [31:0] data,
                       input logic err);
        stim_q.push_back({kind, off, data, err});
    endtask

    // write command, then wait for idle
    task automatic add_axi_write(input logic [31:0] addr, input logic [31:0] data);
        add(KindWr, regmap_pkg::OFF_ADDR, addr, 1'b0);
        add(KindWr, regmap_pkg::OFF_WDATA, data, 1'b0);
        add(KindWr, regmap_pkg::OFF_CMD, 32'h1, 1'b0);
        add(KindIdle, 8'h00, 32'h0, 1'b0);
        exp_beats++;
    endtask

    // read command, wait, then the selected lane
    task automatic add_axi_read(input logic [31:0] addr, input logic [31:0] want);
        add(KindWr, regmap_pkg::OFF_ADDR, addr, 1'b0);
        add(KindWr, regmap_pkg::OFF_CMD, 32'h2, 1'b0);
        add(KindIdle, 8'h00, 32'h0, 1'b0);
        add(KindRd, regmap_pkg::OFF_RDATA, want, 1'b0);
    endtask

    task automatic build_table();
        add(KindWr, regmap_pkg::OFF_OP_A, 32'h1111_1111, 1'b0);
        add(KindWr, regmap_pkg::OFF_OP_B, 32'h2222_2222, 1'b0);
        add(KindRd, regmap_pkg::OFF_OP_A, 32'h1111_1111, 1'b0);
        add(KindRd, regmap_pkg::OFF_OP_B, 32'h2222_2222, 1'b0);
        add(KindRd, regmap_pkg::OFF_SUM, 32'h3333_3333, 1'b0);
        // sum wraps past 2^32
        add(KindWr, regmap_pkg::OFF_OP_A, 32'hFFFF_FFF0, 1'b0);
        add(KindWr, regmap_pkg::OFF_OP_B, 32'h0000_0025, 1'b0);
        add(KindRd, regmap_pkg::OFF_SUM, 32'h0000_0015, 1'b0);
        add(KindWr, regmap_pkg::OFF_ADDR, 32'h0000_0ABC, 1'b0);
        add(KindRd, regmap_pkg::OFF_ADDR, 32'h0000_0ABC, 1'b0);
        add(KindWr, regmap_pkg::OFF_WDATA, 32'hCAFE_F00D, 1'b0);
        add(KindRd, regmap_pkg::OFF_WDATA, 32'hCAFE_F00D, 1'b0);
        // unmapped offsets and read-only writes
        add(KindRd, 8'h0C, 32'h0, 1'b1);
        add(KindRd, 8'h44, 32'h0, 1'b1);
        add(KindWr, regmap_pkg::OFF_SUM, 32'h1234_5678, 1'b1);
        add(KindRd, regmap_pkg::OFF_SUM, 32'h0000_0015, 1'b0);
        add(KindWr, regmap_pkg::OFF_STATUS, 32'h3, 1'b1);
        add(KindRd, regmap_pkg::OFF_CMD, 32'h0, 1'b0);
        add(KindRd, regmap_pkg::OFF_STATUS, 32'h0, 1'b0);
        // lower then upper lane of one word
        add_axi_write(32'h100, 32'hDEAD_BEEF);
        add_axi_write(32'h104, 32'h1234_5678);
        add_axi_read(32'h100, 32'hDEAD_BEEF);
        add_axi_read(32'h104, 32'h1234_5678);
        add(KindRd, regmap_pkg::OFF_STATUS, 32'h0, 1'b0);
        // four words, both lanes, read back in reverse
        for (int i = 0; i < 4; i++) begin
            add_axi_write(32'h200 + 32'(i * 12), 32'hA500_0000 + 32'(i));
        end
        for (int i = 3; i >= 0; i--) begin
            add_axi_read(32'h200 + 32'(i * 12), 32'hA500_0000 + 32'(i));
        end
    endtask

    // setup then access cycle, read data taken mid access
    task automatic apb_xfer(input logic wr, input logic [7:0] off, input logic [31:0] wdata,
                            input logic check, output logic [31:0] rd);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = {24'h0, off};
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        chk_en          = check;
        @(negedge clk);
        rd = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req = '0;
        chk_en  = 1'b0;
    endtask

    // poll status until both busy bits drop
    task automatic wait_idle();
        logic [31:0] st;
        do begin
            apb_xfer(1'b0, regmap_pkg::OFF_STATUS, 32'h0, 1'b0, st);
        end while (st != 32'h0);
    endtask

    initial begin
        apb_req     = '0;
        chk_en      = 1'b0;
        chk_data    = 1'b0;
        exp_prdata  = '0;
        exp_pslverr = 1'b0;
        build_table();
        timeout_cycles = stim_q.size() * 40;
        @(posedge rst_n);
        foreach (stim_q[i]) begin
            exp_prdata  = stim_q[i].data;
            exp_pslverr = stim_q[i].err;
            case (stim_q[i].kind)
                KindWr: begin
                    chk_data = 1'b0;
                    apb_xfer(1'b1, stim_q[i].off, stim_q[i].data, 1'b1, rdata);
                end
                KindRd: begin
                    chk_data = 1'b1;
                    apb_xfer(1'b0, stim_q[i].off, 32'h0, 1'b1, rdata);
                end
                default: wait_idle();
            endcase
        end
        repeat (2) @(posedge clk);
        if (beats != exp_beats) $display("wrong number of AXI write beats seen");
        $display("errors: apb %0d, axi %0d, write beats %0d of %0d",
                 apb_errs, axi_errs, beats, exp_beats);
        if (apb_errs == 0 && axi_errs == 0 && beats == exp_beats) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("timeout, run did not end within %0d cycles", timeout_cycles);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// File: list.f
src/bus_pkg.sv
src/regmap_pkg.sv
src/test_reg_block.sv
src/axi_single_master.sv
src/axi_test_periph.sv
sim/tb_clk_gen.sv
sim/tb_axi_mem.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= list.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Verification failed" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
